/* source/sensor_pkg.sv */
package sensor_pkg;

	// --------------------------------------------------------------------------
	// data bus geometry
	// --------------------------------------------------------------------------
	localparam int DATA_WIDTH  = 12;                       // bits per channel
	localparam int CHANNEL_NUM = 4;                        // pixels per beat
	localparam int DOUT_WIDTH  = DATA_WIDTH * CHANNEL_NUM; // 48 bit bus
	localparam int CNT_WIDTH   = 16;                       // geometry inputs, counters

	// fval to lval distance in align mode, also aligner delay
	localparam int ALIGN_DELAY = 3;

	// --------------------------------------------------------------------------
	// prbs, galois form, right shift
	// --------------------------------------------------------------------------
	localparam logic [15:0] PRBS_SEED = 16'hACE1;
	localparam logic [15:0] PRBS_TAPS = 16'hB400; // x^16+x^14+x^13+x^11

	// --------------------------------------------------------------------------
	// frame generator states
	// --------------------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE,       // fval low, geometry sampled here
		ST_FRONT,      // fval high, waiting front porch
		ST_ACTIVE,     // lval high, width beats
		ST_HIDE,       // line blanking between lines
		ST_BACK,       // after last line, before fval falls
		ST_FRAME_HIDE  // frame blanking
	} timing_state_e;

	// test pattern select
	typedef enum logic [1:0] {
		PAT_PIX_INC,   // beat * CHANNEL_NUM + channel
		PAT_LINE_INC,  // line index on all channels
		PAT_FRAME_INC, // frame counter on all channels
		PAT_PRBS       // lfsr low bits xor channel
	} pattern_e;

endpackage

/* source/frame_line_timing.sv */
module frame_line_timing import sensor_pkg::*; (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  logic                 i_pause_en,      // hold in idle
	input  logic                 i_continue_lval, // lval rhythm during frame blanking
	input  logic [CNT_WIDTH-1:0] i_width,
	input  logic [CNT_WIDTH-1:0] i_line_hide,
	input  logic [CNT_WIDTH-1:0] i_height,
	input  logic [CNT_WIDTH-1:0] i_frame_hide,
	input  logic [CNT_WIDTH-1:0] i_front_porch,
	input  logic [CNT_WIDTH-1:0] i_back_porch,
	output logic                 o_fval,
	output logic                 o_lval
);

	timing_state_e state;
	timing_state_e state_nxt;
	timing_state_e after_back; // where to go once back porch is done
	timing_state_e after_last; // where to go after the last line

	// geometry, frozen for one frame
	logic [CNT_WIDTH-1:0] width_r;
	logic [CNT_WIDTH-1:0] line_hide_r;
	logic [CNT_WIDTH-1:0] height_r;
	logic [CNT_WIDTH-1:0] frame_hide_r;
	logic [CNT_WIDTH-1:0] front_porch_r;
	logic [CNT_WIDTH-1:0] back_porch_r;

	logic [CNT_WIDTH-1:0] cnt;      // cycles in current segment
	logic [CNT_WIDTH-1:0] cnt_inc;
	logic [CNT_WIDTH-1:0] line_cnt; // lines done in this frame
	logic [CNT_WIDTH-1:0] line_inc;
	logic                 seg_end;  // last cycle of current segment

	// blanking line rhythm
	logic                 blk_on;   // 1 = lval phase
	logic [CNT_WIDTH-1:0] blk_cnt;
	logic [CNT_WIDTH-1:0] blk_inc;
	logic                 blk_end;

	assign cnt_inc  = cnt + 1'b1;
	assign line_inc = line_cnt + 1'b1;
	assign blk_inc  = blk_cnt + 1'b1;

	// zero length segments are skipped
	assign after_back = (frame_hide_r == '0) ? ST_IDLE : ST_FRAME_HIDE;
	assign after_last = (back_porch_r == '0) ? after_back : ST_BACK;

	// --------------------------------------------------------------------------
	// next state
	// --------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		seg_end   = 1'b0;
		case (state)
			ST_IDLE: begin
				// porch input used directly, it is latched this same cycle
				if (!i_pause_en) begin
					state_nxt = (i_front_porch == '0) ? ST_ACTIVE : ST_FRONT;
				end
			end
			ST_FRONT: begin
				if (cnt_inc == front_porch_r) begin
					seg_end   = 1'b1;
					state_nxt = ST_ACTIVE;
				end
			end
			ST_ACTIVE: begin
				if (cnt_inc == width_r) begin
					seg_end = 1'b1;
					if (line_inc == height_r) begin
						state_nxt = after_last;
					end else if (line_hide_r == '0) begin
						state_nxt = ST_ACTIVE; // back to back lines
					end else begin
						state_nxt = ST_HIDE;
					end
				end
			end
			ST_HIDE: begin
				if (cnt_inc == line_hide_r) begin
					seg_end   = 1'b1;
					state_nxt = ST_ACTIVE;
				end
			end
			ST_BACK: begin
				if (cnt_inc == back_porch_r) begin
					seg_end   = 1'b1;
					state_nxt = after_back;
				end
			end
			ST_FRAME_HIDE: begin
				if (cnt_inc == frame_hide_r) begin
					seg_end   = 1'b1;
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= ST_IDLE;
			cnt      <= '0;
			line_cnt <= '0;
		end else begin
			state <= state_nxt;
			cnt   <= (state == ST_IDLE || seg_end) ? '0 : cnt_inc;
			if (state == ST_IDLE) begin
				line_cnt <= '0;
			end else if (state == ST_ACTIVE && seg_end) begin
				line_cnt <= line_inc; // one more line finished
			end
		end
	end

	// sample geometry only while idle
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			width_r       <= i_width;
			line_hide_r   <= i_line_hide;
			height_r      <= i_height;
			frame_hide_r  <= i_frame_hide;
			front_porch_r <= i_front_porch;
			back_porch_r  <= i_back_porch;
		end
	end

	// --------------------------------------------------------------------------
	// blanking lval, starts with a hide phase at frame hide entry
	// --------------------------------------------------------------------------
	assign blk_end = blk_on ? (blk_inc == width_r) : (blk_inc == line_hide_r);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			blk_on  <= 1'b0;
			blk_cnt <= '0;
		end else if (state != ST_FRAME_HIDE) begin
			blk_on  <= (line_hide_r == '0); // no hide, lval stays high
			blk_cnt <= '0;
		end else if (blk_end) begin
			blk_on  <= !blk_on || (line_hide_r == '0);
			blk_cnt <= '0;
		end else begin
			blk_cnt <= blk_inc;
		end
	end

	assign o_fval = state inside {ST_FRONT, ST_ACTIVE, ST_HIDE, ST_BACK};
	assign o_lval = (state == ST_ACTIVE) ||
		(state == ST_FRAME_HIDE && i_continue_lval && blk_on);

endmodule

/* source/pixel_pattern.sv */
module pixel_pattern import sensor_pkg::*; (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  pattern_e              i_pattern,
	input  logic                  i_fval,
	input  logic                  i_lval,
	output logic                  o_fval,  // i_fval, one cycle later
	output logic                  o_lval,
	output logic [DOUT_WIDTH-1:0] ov_dout
);

	logic [CNT_WIDTH-1:0]  beat_cnt;  // beat within line
	logic [CNT_WIDTH-1:0]  line_cnt;  // line within frame
	logic [CNT_WIDTH-1:0]  frame_cnt; // free running, bumps at fval fall
	logic [15:0]           lfsr;
	logic [15:0]           lfsr_nxt;
	logic                  fval_fall;
	logic                  lval_fall;
	logic [DOUT_WIDTH-1:0] pat_data;

	// registered outputs double as the previous cycle inputs
	assign fval_fall = !i_fval && o_fval;
	assign lval_fall = !i_lval && o_lval;

	assign lfsr_nxt = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? PRBS_TAPS : 16'h0000);

	// --------------------------------------------------------------------------
	// position counters
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			beat_cnt  <= '0;
			line_cnt  <= '0;
			frame_cnt <= '0;
			lfsr      <= PRBS_SEED;
		end else begin
			// beat restarts every line
			if (!i_lval) begin
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end

			// line restarts every frame
			if (!i_fval) begin
				line_cnt <= '0;
			end else if (lval_fall) begin
				line_cnt <= line_cnt + 1'b1;
			end

			if (fval_fall) begin
				frame_cnt <= frame_cnt + 1'b1;
			end

			// seed held through blanking, so each frame starts from it
			if (!i_fval) begin
				lfsr <= PRBS_SEED;
			end else if (i_lval) begin
				lfsr <= lfsr_nxt; // one step per active beat
			end
		end
	end

	// --------------------------------------------------------------------------
	// pattern select, per channel
	// --------------------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < CHANNEL_NUM; k++) begin
			case (i_pattern)
				PAT_PIX_INC: begin
					pat_data[k*DATA_WIDTH +: DATA_WIDTH] =
						DATA_WIDTH'(beat_cnt * CHANNEL_NUM + k);
				end
				PAT_LINE_INC: begin
					pat_data[k*DATA_WIDTH +: DATA_WIDTH] = line_cnt[DATA_WIDTH-1:0];
				end
				PAT_FRAME_INC: begin
					pat_data[k*DATA_WIDTH +: DATA_WIDTH] = frame_cnt[DATA_WIDTH-1:0];
				end
				PAT_PRBS: begin
					// channel index keeps lanes distinct
					pat_data[k*DATA_WIDTH +: DATA_WIDTH] =
						lfsr[DATA_WIDTH-1:0] ^ DATA_WIDTH'(k);
				end
			endcase
		end
	end

	// one cycle stage, data zero outside valid beats
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_fval  <= 1'b0;
			o_lval  <= 1'b0;
			ov_dout <= '0;
		end else begin
			o_fval  <= i_fval;
			o_lval  <= i_lval;
			ov_dout <= (i_fval && i_lval) ? pat_data : '0;
		end
	end

endmodule

/* source/fval_lval_align.sv */
module fval_lval_align import sensor_pkg::*; (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_align_en, // 1 = regenerated fval
	input  logic                  i_fval,
	input  logic                  i_lval,
	input  logic [DOUT_WIDTH-1:0] iv_din,
	output logic                  o_fval,
	output logic                  o_lval,
	output logic [DOUT_WIDTH-1:0] ov_dout
);

	logic [ALIGN_DELAY:0]   lval_sr;  // top bit is o_lval one cycle late
	logic [ALIGN_DELAY-1:0] fval_sr;
	logic [DOUT_WIDTH-1:0]  dout_sr [ALIGN_DELAY];

	logic       armed;      // frame open, first lval not seen yet
	logic       armed_now;
	logic       start;      // first lval of frame at our input
	logic       out_fall;   // delayed lval just fell
	logic       fval_r;     // regenerated fval after start cycle
	logic [1:0] tail_cnt;   // cycles left before fval drops

	// --------------------------------------------------------------------------
	// delay line
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			lval_sr <= '0;
			fval_sr <= '0;
			for (int i = 0; i < ALIGN_DELAY; i++) begin
				dout_sr[i] <= '0;
			end
		end else begin
			lval_sr    <= {lval_sr[ALIGN_DELAY-1:0], i_lval};
			fval_sr    <= {fval_sr[ALIGN_DELAY-2:0], i_fval};
			dout_sr[0] <= iv_din;
			for (int i = 1; i < ALIGN_DELAY; i++) begin
				dout_sr[i] <= dout_sr[i-1];
			end
		end
	end

	// --------------------------------------------------------------------------
	// regenerated fval
	// --------------------------------------------------------------------------
	// fval and lval may rise together when front porch is zero
	assign armed_now = armed || (i_fval && !fval_sr[0]);
	assign start     = armed_now && i_lval && !lval_sr[0];
	// only the fall after input fval dropped ends the frame
	assign out_fall  = lval_sr[ALIGN_DELAY] && !lval_sr[ALIGN_DELAY-1] && !i_fval;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			armed    <= 1'b0;
			fval_r   <= 1'b0;
			tail_cnt <= '0;
		end else begin
			armed <= armed_now && !start;
			if (start) begin
				fval_r <= 1'b1;
			end else if (tail_cnt == 2'd1) begin
				fval_r <= 1'b0; // third cycle after the lval fall
			end

			if (tail_cnt != '0) begin
				tail_cnt <= tail_cnt - 1'b1;
			end else if (out_fall && fval_r) begin
				tail_cnt <= 2'(ALIGN_DELAY - 1);
			end
		end
	end

	// start cycle passes straight through so fval leads lval by ALIGN_DELAY
	assign o_fval  = i_align_en ? (fval_r || start) : fval_sr[ALIGN_DELAY-1];
	assign o_lval  = lval_sr[ALIGN_DELAY-1];
	assign ov_dout = dout_sr[ALIGN_DELAY-1];

endmodule

/* source/sensor_model.sv */
module sensor_model import sensor_pkg::*; (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_pause_en,
	input  logic                  i_continue_lval,
	input  logic                  i_align_en,
	input  logic                  i_clk_invert,    // 1 = data on falling pixel clock
	input  pattern_e              i_pattern,
	input  logic [CNT_WIDTH-1:0]  i_width,
	input  logic [CNT_WIDTH-1:0]  i_line_hide,
	input  logic [CNT_WIDTH-1:0]  i_height,
	input  logic [CNT_WIDTH-1:0]  i_frame_hide,
	input  logic [CNT_WIDTH-1:0]  i_front_porch,
	input  logic [CNT_WIDTH-1:0]  i_back_porch,
	output logic                  o_clk_pix,
	output logic                  o_fval,
	output logic                  o_lval,
	output logic [DOUT_WIDTH-1:0] ov_dout
);

	logic                  raw_fval;
	logic                  raw_lval;
	logic                  pat_fval;
	logic                  pat_lval;
	logic [DOUT_WIDTH-1:0] pat_data;

	// pixel clock polarity
	assign o_clk_pix = i_clk_invert ? ~clk : clk;

	// --------------------------------------------------------------------------
	// timing -> pattern -> align
	// --------------------------------------------------------------------------
	frame_line_timing u_timing (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_pause_en      (i_pause_en),
		.i_continue_lval (i_continue_lval),
		.i_width         (i_width),
		.i_line_hide     (i_line_hide),
		.i_height        (i_height),
		.i_frame_hide    (i_frame_hide),
		.i_front_porch   (i_front_porch),
		.i_back_porch    (i_back_porch),
		.o_fval          (raw_fval),
		.o_lval          (raw_lval)
	);

	pixel_pattern u_pattern (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_pattern (i_pattern),
		.i_fval    (raw_fval),
		.i_lval    (raw_lval),
		.o_fval    (pat_fval),
		.o_lval    (pat_lval),
		.ov_dout   (pat_data)
	);

	fval_lval_align u_align (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_align_en (i_align_en),
		.i_fval     (pat_fval),
		.i_lval     (pat_lval),
		.iv_din     (pat_data),
		.o_fval     (o_fval),
		.o_lval     (o_lval),
		.ov_dout    (ov_dout)
	);

endmodule

/* tb/sensor_model_assert.sv */
module sensor_model_assert import sensor_pkg::*; (
	input logic                  clk,
	input logic                  i_arst_n,
	input logic                  i_continue_lval,
	input logic                  i_align_en,
	input logic                  o_fval,
	input logic                  o_lval,
	input logic [DOUT_WIDTH-1:0] ov_dout
);
	timeunit 1ns;
	timeprecision 1ns;

	int fail_cnt = 0; // failed assertion count

	// --------------------------------------------------------------------------
	// output timing rules
	// --------------------------------------------------------------------------
	// lines only inside a frame, blanking pulses excepted
	a_lval_in_frame: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_lval) |-> (o_fval || i_continue_lval))
		else begin
			fail_cnt++;
			$error("o_lval rose while o_fval was low");
		end

	// no data outside a line
	a_dout_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
		!o_lval |-> (ov_dout == '0))
		else begin
			fail_cnt++;
			$error("ov_dout not zero while o_lval low");
		end

	// fixed lead of fval over the first line
	a_align_lead: assert property (@(posedge clk) disable iff (!i_arst_n)
		(i_align_en && $rose(o_fval)) |-> ##ALIGN_DELAY $rose(o_lval))
		else begin
			fail_cnt++;
			$error("o_lval did not rise three cycles after o_fval in align mode");
		end

endmodule

bind sensor_model sensor_model_assert u_assert (
	.clk             (clk),
	.i_arst_n        (i_arst_n),
	.i_continue_lval (i_continue_lval),
	.i_align_en      (i_align_en),
	.o_fval          (o_fval),
	.o_lval          (o_lval),
	.ov_dout         (ov_dout)
);

/* tb/tb_sensor_model.sv */
module tb_sensor_model import sensor_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	logic                  clk = 1'b0;
	logic                  i_arst_n = 1'b0;
	logic                  i_pause_en = 1'b0;
	logic                  i_continue_lval = 1'b0;
	logic                  i_align_en = 1'b0;
	logic                  i_clk_invert = 1'b0;
	pattern_e              i_pattern = PAT_PIX_INC;
	logic [CNT_WIDTH-1:0]  i_width = '0;
	logic [CNT_WIDTH-1:0]  i_line_hide = '0;
	logic [CNT_WIDTH-1:0]  i_height = '0;
	logic [CNT_WIDTH-1:0]  i_frame_hide = '0;
	logic [CNT_WIDTH-1:0]  i_front_porch = '0;
	logic [CNT_WIDTH-1:0]  i_back_porch = '0;
	logic                  o_clk_pix;
	logic                  o_fval;
	logic                  o_lval;
	logic [DOUT_WIDTH-1:0] ov_dout;

	// golden table, one entry per test
	string       t_name [16];
	int          t_pat [16], t_w [16], t_lh [16], t_h [16], t_fh [16], t_fp [16], t_bp [16];
	int          t_cont [16], t_align [16], t_inv [16], t_pause [16];
	int          t_lines [16], t_beats [16], t_dist [16], t_tail [16];
	logic [63:0] t_first [16], t_last [16];
	int          n_tests = 0;

	int          errors = 0;
	int          checks = 0;
	int          limit_ns = 0;
	logic        fv, lv, fval_q, lval_q; // sampled outputs, current and previous
	logic [DOUT_WIDTH-1:0] dv;

	always #50 clk = ~clk;

	sensor_model UUT (.*);

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// one clock, sampled mid cycle where outputs are stable
	task automatic tick();
		fval_q = fv;
		lval_q = lv;
		@(negedge clk);
		fv = o_fval;
		lv = o_lval;
		dv = ov_dout;
	endtask

	// pixel clock seen in both phases of one cycle, ends on a falling edge
	task automatic check_clk_pix(input int t);
		#25;
		check_value({t_name[t], " pixel clock low phase"}, 64'(t_inv[t] != 0), 64'(o_clk_pix));
		#50;
		check_value({t_name[t], " pixel clock high phase"}, 64'(t_inv[t] == 0), 64'(o_clk_pix));
		tick();
	endtask

	task automatic load_golden();
		int    fd;
		int    n;
		string line;
		string nm;
		int    v [15];
		logic [63:0] f, l;
		fd = $fopen("tb/sensor_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file tb/sensor_golden.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#") continue; // comment or blank
			n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %d %d", nm,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12],
				f, l, v[13], v[14]);
			if (n != 18) begin
				errors++;
				$display("golden line could not be parsed: %s", line);
				continue;
			end
			t_name[n_tests]  = nm;
			t_pat[n_tests]   = v[0];
			t_w[n_tests]     = v[1];
			t_lh[n_tests]    = v[2];
			t_h[n_tests]     = v[3];
			t_fh[n_tests]    = v[4];
			t_fp[n_tests]    = v[5];
			t_bp[n_tests]    = v[6];
			t_cont[n_tests]  = v[7];
			t_align[n_tests] = v[8];
			t_inv[n_tests]   = v[9];
			t_pause[n_tests] = v[10];
			t_lines[n_tests] = v[11];
			t_beats[n_tests] = v[12];
			t_first[n_tests] = f;
			t_last[n_tests]  = l;
			t_dist[n_tests]  = v[13];
			t_tail[n_tests]  = v[14];
			n_tests++;
		end
		$fclose(fd);
	endtask

	// --------------------------------------------------------------------------
	// one frame, from fval rise to fval fall, blanking seen on the way in
	// --------------------------------------------------------------------------
	task automatic run_frame(input int t, input int fr, ref int blank,
		output logic [63:0] first, output logic [63:0] last);
		int cyc = 0;
		int lines = 0;
		int beats = 0;
		int first_rise = -1;
		int last_fall = 0;
		while (!(fv && !fval_q)) begin
			tick();
			if (!fv && lv && !lval_q) blank++;
			if (!fv && lv && dv != '0) begin
				errors++;
				$display("%s: nonzero data on a blanking line", t_name[t]);
			end
		end
		forever begin
			if (lv && !lval_q) begin
				lines++;
				beats = 0;
				if (first_rise < 0) begin
					first_rise = cyc;
					first = 64'(dv);
				end
			end
			if (lv) begin
				beats++;
				last = 64'(dv);
			end
			if (!lv && lval_q) begin
				check_value({t_name[t], " beats"}, 64'(t_beats[t]), 64'(beats));
				last_fall = cyc;
			end
			if (!fv) break;
			tick();
			cyc++;
		end
		check_value({t_name[t], " lines"}, 64'(t_lines[t]), 64'(lines));
		check_value({t_name[t], " fval to lval"}, 64'(t_dist[t]), 64'(first_rise));
		check_value({t_name[t], " lval to fval fall"}, 64'(t_tail[t]), 64'(cyc - last_fall));
		if (fr == 2) begin
			check_value({t_name[t], " first word"}, t_first[t], first);
			check_value({t_name[t], " last word"}, t_last[t], last);
		end
	endtask

	task automatic run_test(input int t);
		int          blank = 0;
		logic [63:0] first [3];
		logic [63:0] last [3];
		repeat ($urandom_range(1, 8)) tick(); // random gap between tests
		i_arst_n        = 1'b0;
		i_pattern       = pattern_e'(t_pat[t]);
		i_width         = CNT_WIDTH'(t_w[t]);
		i_line_hide     = CNT_WIDTH'(t_lh[t]);
		i_height        = CNT_WIDTH'(t_h[t]);
		i_frame_hide    = CNT_WIDTH'(t_fh[t]);
		i_front_porch   = CNT_WIDTH'(t_fp[t]);
		i_back_porch    = CNT_WIDTH'(t_bp[t]);
		i_continue_lval = (t_cont[t] != 0);
		i_align_en      = (t_align[t] != 0);
		i_clk_invert    = (t_inv[t] != 0);
		i_pause_en      = (t_pause[t] != 0);
		repeat (8) tick();
		i_arst_n = 1'b1;
		for (int i = 0; i < t_pause[t]; i++) begin
			tick();
			if (fv) begin
				errors++;
				$display("%s: frame started while pause was held", t_name[t]);
			end
		end
		i_pause_en = 1'b0;
		for (int fr = 1; fr <= 3; fr++) begin
			run_frame(t, fr, blank, first[fr-1], last[fr-1]);
		end
		if (pattern_e'(t_pat[t]) == PAT_FRAME_INC) begin
			check_value({t_name[t], " frame step"}, first[1] + 64'h001001001001, first[2]);
		end
		if (pattern_e'(t_pat[t]) == PAT_PRBS) begin
			check_value({t_name[t], " prbs repeat first"}, first[0], first[2]);
			check_value({t_name[t], " prbs repeat last"}, last[0], last[2]);
		end
		check_value({t_name[t], " blanking lines"}, 64'(t_cont[t] != 0), 64'(blank > 0));
		check_clk_pix(t);
	endtask

	initial begin
		void'($urandom(40));
		fv     = 1'b0;
		lv     = 1'b0;
		dv     = '0;
		fval_q = 1'b0;
		lval_q = 1'b0;
		load_golden();
		for (int t = 0; t < n_tests; t++) begin
			limit_ns += 100 * (3 * (10 + t_fp[t] + t_h[t] * (t_w[t] + t_lh[t]) + t_bp[t] + t_fh[t])
				+ 20 + t_pause[t]);
		end
		limit_ns = 2 * limit_ns;
		for (int t = 0; t < n_tests; t++) run_test(t);
		errors += UUT.u_assert.fail_cnt; // bound checker failures
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0 && n_tests > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog, armed once the golden table is known
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("timeout, frames did not complete in time");
		$display("TB FAILED");
		$finish;
	end

endmodule

/* tb/sensor_golden.txt */
# name pattern width line_hide height frame_hide front_porch back_porch continue align invert pause
#   exp_lines exp_beats exp_first(hex) exp_last(hex) exp_fval_to_lval exp_lval_to_fval_fall
pix_basic  0 8 4 5 10 2 1 0 0 0 0  5 8 003002001000 01F01E01D01C 2 1
line_inc   1 6 5 5 8  5 3 0 0 1 0  5 6 000000000000 004004004004 5 3
frame_inc  2 4 4 3 6  1 2 0 0 0 0  3 4 001001001001 001001001001 1 2
prbs_seed  3 2 4 1 6  3 1 0 0 0 0  1 2 CE2CE3CE0CE1 273272271270 3 1
align_a    0 5 4 4 8  7 0 0 1 0 0  4 5 003002001000 013012011010 3 3
align_b    1 3 6 2 5  0 3 0 1 1 0  2 3 000000000000 001001001001 3 3
cont_lval  0 4 4 2 20 2 1 1 0 0 0  2 4 003002001000 00F00E00D00C 2 1
pause_hold 1 4 4 3 6  2 2 0 0 0 30 3 4 000000000000 002002002002 2 2

/* sensor_model.f */
source/sensor_pkg.sv
source/frame_line_timing.sv
source/pixel_pattern.sv
source/fval_lval_align.sv
source/sensor_model.sv
tb/sensor_model_assert.sv
tb/tb_sensor_model.sv

/* Makefile */
TOP = tb_sensor_model

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sensor_model.f -o vsim
	out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir
